// File: common/rvDecodePkg.sv
package rvDecodePkg;

    // --------------------------------------------------
    // Sizes
    // --------------------------------------------------

    // Data path width
    localparam int XLEN = 32;
    // Register address width and register count
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS = 32;
    // Instruction field widths
    localparam int OPCODE_W = 7;
    localparam int FUNCT3_W = 3;
    localparam int FUNCT7_W = 7;

    // Ecall taps, a0 holds the argument and a7 the call code
    localparam logic [REG_ADDR_W-1:0] REG_A0 = 5'd10;
    localparam logic [REG_ADDR_W-1:0] REG_A7 = 5'd17;

    // --------------------------------------------------
    // Encodings
    // --------------------------------------------------

    // RV32I major opcodes
    typedef enum logic [OPCODE_W-1:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OPIMM  = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_SYSTEM = 7'b1110011
    } opcodeE;

    // Load width, taken from funct3 of a load
    typedef enum logic [FUNCT3_W-1:0] {
        LD_LB  = 3'b000,
        LD_LH  = 3'b001,
        LD_LW  = 3'b010,
        LD_LBU = 3'b100,
        LD_LHU = 3'b101
    } loadFunctE;

    // --------------------------------------------------
    // Structs
    // --------------------------------------------------

    // Fields split out of one instruction word
    typedef struct packed {
        logic [OPCODE_W-1:0]   opcode;
        logic [REG_ADDR_W-1:0] rdAddr;
        logic [FUNCT3_W-1:0]   funct3;
        logic [REG_ADDR_W-1:0] rs1Addr;
        logic [REG_ADDR_W-1:0] rs2Addr;
        logic [FUNCT7_W-1:0]   funct7;
    } instFieldsT;

    // Retiring instruction as seen by writeback
    typedef struct packed {
        logic                  regWrite;
        logic                  isLink;
        logic                  memToReg;
        logic [FUNCT3_W-1:0]   funct3;
        logic [REG_ADDR_W-1:0] rdAddr;
        logic [XLEN-1:0]       aluResult;
        logic [XLEN-1:0]       memData;
        logic [XLEN-1:0]       pc;
    } wbReqT;

    // Everything decode hands to execute
    typedef struct packed {
        instFieldsT      fields;
        logic [XLEN-1:0] rdata1;
        logic [XLEN-1:0] rdata2;
        logic [XLEN-1:0] imm32;
    } decodeOutT;

endpackage

// File: decode/immGen.sv
module immGen
    import rvDecodePkg::*;
(
    input  logic [XLEN-1:0] inst,
    output logic [XLEN-1:0] imm32
);

    opcodeE opcode;

    // Sign bit of every format
    logic signBit;

    // Per-format immediates
    logic [XLEN-1:0] immI;
    logic [XLEN-1:0] immS;
    logic [XLEN-1:0] immB;
    logic [XLEN-1:0] immU;
    logic [XLEN-1:0] immJ;

    assign opcode  = opcodeE'(inst[OPCODE_W-1:0]);
    assign signBit = inst[XLEN-1];

    // --------------------------------------------------
    // Format assembly
    // --------------------------------------------------

    // I format, 12 bits straight from the top
    assign immI = {{(XLEN-12){signBit}}, inst[31:20]};

    // S format, split around rd
    assign immS = {{(XLEN-12){signBit}}, inst[31:25], inst[11:7]};

    // B format, halfword aligned
    assign immB = {{(XLEN-13){signBit}}, inst[31], inst[7], inst[30:25],
                   inst[11:8], 1'b0};

    // U format, upper 20 bits
    assign immU = {inst[31:12], 12'b0};

    // J format, halfword aligned, 21 bits
    assign immJ = {{(XLEN-21){signBit}}, inst[31], inst[19:12], inst[20],
                   inst[30:21], 1'b0};

    // --------------------------------------------------
    // Select by opcode
    // --------------------------------------------------
    always_comb begin
        case (opcode)
            OPC_OPIMM, OPC_LOAD,
            OPC_JALR, OPC_SYSTEM: imm32 = immI;
            OPC_STORE:            imm32 = immS;
            OPC_BRANCH:           imm32 = immB;
            OPC_LUI, OPC_AUIPC:   imm32 = immU;
            OPC_JAL:              imm32 = immJ;
            // OP and unknown opcodes carry no immediate
            default:              imm32 = '0;
        endcase
    end

endmodule

// File: decode/writebackSelect.sv
module writebackSelect
    import rvDecodePkg::*;
(
    input  wbReqT           wb,
    output logic [XLEN-1:0] wdata
);

    loadFunctE loadFunct;

    // Load value after extension
    logic [XLEN-1:0] loadData;

    // Return address of a jump-and-link
    logic [XLEN-1:0] linkAddr;

    assign loadFunct = loadFunctE'(wb.funct3);
    assign linkAddr  = wb.pc + XLEN'(4);

    // --------------------------------------------------
    // Load extension
    // --------------------------------------------------
    always_comb begin
        case (loadFunct)
            // Byte, sign from bit 7
            LD_LB:   loadData = {{(XLEN-8){wb.memData[7]}}, wb.memData[7:0]};
            // Halfword, sign from bit 15
            LD_LH:   loadData = {{(XLEN-16){wb.memData[15]}}, wb.memData[15:0]};
            LD_LW:   loadData = wb.memData;
            LD_LBU:  loadData = {{(XLEN-8){1'b0}}, wb.memData[7:0]};
            LD_LHU:  loadData = {{(XLEN-16){1'b0}}, wb.memData[15:0]};
            // Invalid width writes zero
            default: loadData = '0;
        endcase
    end

    // --------------------------------------------------
    // Result select
    // --------------------------------------------------

    // Link beats load, load beats ALU
    always_comb begin
        if (wb.isLink) begin
            wdata = linkAddr;
        end else if (wb.memToReg) begin
            wdata = loadData;
        end else begin
            wdata = wb.aluResult;
        end
    end

endmodule

// File: decode/registerFile.sv
module registerFile
    import rvDecodePkg::*;
(
    input  logic                  clk,
    input  logic                  rstN,
    // Read addresses
    input  logic [REG_ADDR_W-1:0] raddr1,
    input  logic [REG_ADDR_W-1:0] raddr2,
    // Write port
    input  logic [REG_ADDR_W-1:0] waddr,
    input  logic [XLEN-1:0]       wdata,
    input  logic                  regWrite,
    // Read data
    output logic [XLEN-1:0]       rdata1,
    output logic [XLEN-1:0]       rdata2,
    // Taps for the ecall handler
    output logic [XLEN-1:0]       a7Data,
    output logic [XLEN-1:0]       a0Data
);

    logic [XLEN-1:0] regs [NUM_REGS];

    // Write is live this cycle unless it targets x0
    logic writeLive;
    assign writeLive = regWrite && (waddr != '0);

    // --------------------------------------------------
    // Write port
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            // All registers come up zero
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (writeLive) begin
            regs[waddr] <= wdata;
        end
    end

    // --------------------------------------------------
    // Read ports with forwarding
    // --------------------------------------------------

    // One read with x0 hardwired to zero
    // Same-cycle write to the address wins over the stored value
    function automatic logic [XLEN-1:0] readReg(input logic [REG_ADDR_W-1:0] addr);
        logic [XLEN-1:0] value;
        if (addr == '0) begin
            value = '0;
        end else if (writeLive && (waddr == addr)) begin
            value = wdata;
        end else begin
            value = regs[addr];
        end
        return value;
    endfunction

    always_comb begin
        rdata1 = readReg(raddr1);
        rdata2 = readReg(raddr2);
        // Taps see the forwarded value too
        a7Data = readReg(REG_A7);
        a0Data = readReg(REG_A0);
    end

endmodule

// File: decode/decodeStage.sv
module decodeStage
    import rvDecodePkg::*;
(
    input  logic            clk,
    input  logic            rstN,
    // Fetched instruction
    input  logic [XLEN-1:0] inst,
    // Retiring instruction
    input  wbReqT           wb,
    output decodeOutT       dec,
    // Ecall taps
    output logic [XLEN-1:0] ecallCode,
    output logic [XLEN-1:0] ecallArg
);

    instFieldsT      fields;
    logic [XLEN-1:0] wdata;
    logic [XLEN-1:0] imm32;
    logic [XLEN-1:0] rdata1;
    logic [XLEN-1:0] rdata2;

    // --------------------------------------------------
    // Field split
    // --------------------------------------------------
    assign fields.opcode  = inst[6:0];
    assign fields.rdAddr  = inst[11:7];
    assign fields.funct3  = inst[14:12];
    assign fields.rs1Addr = inst[19:15];
    assign fields.rs2Addr = inst[24:20];
    assign fields.funct7  = inst[31:25];

    // Bundle for the next stage
    assign dec = '{fields: fields, rdata1: rdata1, rdata2: rdata2, imm32: imm32};

    // --------------------------------------------------
    // Submodules
    // --------------------------------------------------

    // Write value of the retiring instruction
    writebackSelect uWritebackSelect (
        .wb   (wb),
        .wdata(wdata)
    );

    registerFile uRegisterFile (
        .clk     (clk),
        .rstN    (rstN),
        .raddr1  (fields.rs1Addr),
        .raddr2  (fields.rs2Addr),
        .waddr   (wb.rdAddr),
        .wdata   (wdata),
        .regWrite(wb.regWrite),
        .rdata1  (rdata1),
        .rdata2  (rdata2),
        .a7Data  (ecallCode),
        .a0Data  (ecallArg)
    );

    immGen uImmGen (
        .inst (inst),
        .imm32(imm32)
    );

endmodule

// File: tb/decodeStage_asserts.sv
module decodeStageAsserts
    import rvDecodePkg::*;
(
    input logic            clk,
    input logic            rstN,
    input logic [XLEN-1:0] inst,
    input decodeOutT       dec,
    input logic [XLEN-1:0] ecallCode,
    input logic [XLEN-1:0] ecallArg
);

    // One sticky failure flag per property
    logic rs1ZeroFail = 1'b0;
    logic tapResetFail = 1'b0;
    logic fieldSplitFail = 1'b0;
    logic failed;

    assign failed = rs1ZeroFail | tapResetFail | fieldSplitFail;

    // x0 on port 1 always zero
    rs1ZeroA: assert property (@(posedge clk) disable iff (!rstN)
        (inst[19:15] == '0) |-> (dec.rdata1 == '0))
        else begin
            rs1ZeroFail = 1'b1;
            $error("rdata1 nonzero with rs1 address zero");
        end

    // Taps held at zero in reset
    tapResetA: assert property (@(posedge clk)
        !rstN |-> (ecallCode == '0 && ecallArg == '0))
        else begin
            tapResetFail = 1'b1;
            $error("Ecall taps nonzero during reset");
        end

    // Field split follows the instruction bit slices
    fieldSplitA: assert property (@(posedge clk)
        dec.fields.opcode == inst[6:0] && dec.fields.rdAddr == inst[11:7] &&
        dec.fields.funct3 == inst[14:12] && dec.fields.rs1Addr == inst[19:15] &&
        dec.fields.rs2Addr == inst[24:20] && dec.fields.funct7 == inst[31:25])
        else begin
            fieldSplitFail = 1'b1;
            $error("Instruction fields do not match instruction bits");
        end

endmodule

bind decodeStage decodeStageAsserts uAsserts (
    .clk      (clk),
    .rstN     (rstN),
    .inst     (inst),
    .dec      (dec),
    .ecallCode(ecallCode),
    .ecallArg (ecallArg)
);

// File: tb/decodeStageTb.sv
module decodeStageTb
    import rvDecodePkg::*;
();

    localparam int HALF_PERIOD = 4;
    localparam int RESET_CYCLES = 3;
    localparam int RESET_TIMEOUT = 20;
    localparam int RUN_TIMEOUT = 1000;
    // Every major opcode plus one unknown
    localparam logic [6:0] OPCODES [11] = '{OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR,
        OPC_BRANCH, OPC_LOAD, OPC_STORE, OPC_OPIMM, OPC_OP, OPC_SYSTEM, 7'h7F};

    logic            clk;
    logic            rstN;
    logic [XLEN-1:0] inst;
    wbReqT           wb;
    decodeOutT       dec;
    logic [XLEN-1:0] ecallCode;
    logic [XLEN-1:0] ecallArg;

    // Shadow of the register file
    logic [XLEN-1:0] shadow [NUM_REGS];
    int   seed = 65;
    logic stimDone = 1'b0;

    decodeStage u_dut (
        .clk      (clk),
        .rstN     (rstN),
        .inst     (inst),
        .wb       (wb),
        .dec      (dec),
        .ecallCode(ecallCode),
        .ecallArg (ecallArg)
    );

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    initial begin
        rstN <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rstN <= 1'b1;
    end

    // --------------------------------------------------
    // Reference model
    // --------------------------------------------------

    // Immediate per RV32I format
    function automatic logic [XLEN-1:0] refImm(input logic [XLEN-1:0] word);
        case (word[6:0])
            OPC_OPIMM, OPC_LOAD, OPC_JALR, OPC_SYSTEM: return XLEN'($signed(word) >>> 20);
            OPC_STORE:  return {{20{word[31]}}, word[31:25], word[11:7]};
            OPC_BRANCH: return {{20{word[31]}}, word[7], word[30:25], word[11:8], 1'b0};
            OPC_LUI, OPC_AUIPC: return word & 32'hFFFF_F000;
            OPC_JAL:    return {{12{word[31]}}, word[19:12], word[20], word[30:21], 1'b0};
            default:    return '0;
        endcase
    endfunction

    // Link first, then load, then ALU
    function automatic logic [XLEN-1:0] refWdata(input wbReqT req);
        if (req.isLink) return req.pc + 32'd4;
        if (!req.memToReg) return req.aluResult;
        case (req.funct3)
            3'd0:    return XLEN'($signed(req.memData[7:0]));
            3'd1:    return XLEN'($signed(req.memData[15:0]));
            3'd2:    return req.memData;
            3'd4:    return {24'd0, req.memData[7:0]};
            3'd5:    return {16'd0, req.memData[15:0]};
            default: return '0;
        endcase
    endfunction

    // x0 reads zero and a same-cycle write is forwarded
    function automatic logic [XLEN-1:0] expectedRead(input logic [4:0] addr, input wbReqT req);
        if (addr == '0) return '0;
        if (req.regWrite && req.rdAddr == addr) return refWdata(req);
        return shadow[addr];
    endfunction

    // --------------------------------------------------
    // Stimulus helpers
    // --------------------------------------------------
    function automatic logic [XLEN-1:0] randWord();
        return $random(seed);
    endfunction

    function automatic logic [XLEN-1:0] makeInst(input logic [6:0] op);
        logic [XLEN-1:0] word;
        word = randWord();
        return {word[31:7], op};
    endfunction

    function automatic wbReqT randomWb();
        logic [127:0] bits;
        bits = {randWord(), randWord(), randWord(), randWord()};
        return bits[$bits(wbReqT)-1:0];
    endfunction

    task automatic driveCycle(input logic [XLEN-1:0] word, input wbReqT req);
        @(posedge clk);
        inst <= word;
        wb <= req;
    endtask

    task automatic checkValue(input string what, input logic [XLEN-1:0] got,
                              input logic [XLEN-1:0] expected);
        assert (got === expected) else begin
            $display("ERROR at time %0t: %s is %h, expected %h", $time, what, got, expected);
            $display("Simulation finished: FAIL");
            $fatal(1, "Mismatch on %s", what);
        end
    endtask

    // --------------------------------------------------
    // Compare mid-cycle before each rising edge
    // --------------------------------------------------
    initial begin : compareProc
        int cycles;
        logic [XLEN-1:0] expFields;
        cycles = 0;
        for (int r = 0; r < NUM_REGS; r++) shadow[r] = '0;
        while (!stimDone && cycles < RUN_TIMEOUT) begin
            @(negedge clk);
            cycles++;
            // Bound checker flags a failed property
            assert (u_dut.uAsserts.failed !== 1'b1) else begin
                $display("A concurrent assertion in the bound checker failed");
                $display("Simulation finished: FAIL");
                $fatal(1, "Checker failure");
            end
            if (rstN) begin
                expFields = {inst[6:0], inst[11:7], inst[14:12], inst[19:15],
                             inst[24:20], inst[31:25]};
                checkValue("fields", dec.fields, expFields);
                checkValue("imm32", dec.imm32, refImm(inst));
                checkValue("rdata1", dec.rdata1, expectedRead(inst[19:15], wb));
                checkValue("rdata2", dec.rdata2, expectedRead(inst[24:20], wb));
                checkValue("ecallCode", ecallCode, expectedRead(REG_A7, wb));
                checkValue("ecallArg", ecallArg, expectedRead(REG_A0, wb));
                // Write lands on the coming edge
                if (wb.regWrite && wb.rdAddr != '0) shadow[wb.rdAddr] = refWdata(wb);
            end
        end
        if (stimDone) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            $display("Timeout: stimulus still running after %0d cycles", RUN_TIMEOUT);
            $display("Simulation finished: FAIL");
            $fatal(1, "Run timeout");
        end
    end

    // --------------------------------------------------
    // Stimulus
    // --------------------------------------------------
    initial begin : stimulusProc
        int waited;
        logic [XLEN-1:0] word;
        wbReqT req;
        inst <= '0;
        wb <= '0;
        waited = 0;
        while (rstN !== 1'b1 && waited < RESET_TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (rstN !== 1'b1) begin
            $display("Reset was not released within %0d cycles", RESET_TIMEOUT);
            $display("Simulation finished: FAIL");
            $fatal(1, "Reset timeout");
        end
        // Every register on both ports before any write
        for (int i = 0; i < NUM_REGS; i++) begin
            driveCycle({7'd0, 5'(NUM_REGS - 1 - i), 5'(i), 3'd0, 5'd0, OPC_OP}, '0);
        end
        for (int n = 0; n < 220; n++) begin
            req = randomWb();
            word = makeInst(OPCODES[n % 11]);
            case (n / 44)
                // ALU results with every eighth aimed at x0 and read from it
                0: begin
                    req.isLink = 1'b0;
                    req.memToReg = 1'b0;
                    if (n % 8 == 0) begin
                        req.rdAddr = '0;
                        word[19:15] = '0;
                    end
                end
                // Loads of all funct3 values with sign bits set and cleared
                1: begin
                    req.isLink = 1'b0;
                    req.memToReg = 1'b1;
                    req.funct3 = 3'(n);
                    if ((n / 8) % 2 == 0) req.memData = req.memData | 32'h0000_8080;
                    else req.memData = req.memData & 32'hFFFF_7F7F;
                    word[19:15] = req.rdAddr;
                end
                // Link with memToReg left random
                2: begin
                    req.isLink = 1'b1;
                    word[19:15] = req.rdAddr;
                end
                // Write and read of one register on the taps and elsewhere
                3: begin
                    if (n % 3 == 0) req.rdAddr = REG_A7;
                    else if (n % 3 == 1) req.rdAddr = REG_A0;
                    word[19:15] = req.rdAddr;
                    word[24:20] = req.rdAddr;
                end
                default: ;
            endcase
            if (n < 176) req.regWrite = 1'b1;
            driveCycle(word, req);
        end
        driveCycle('0, '0);
        @(posedge clk);
        stimDone = 1'b1;
    end

endmodule

// File: decodeStage.f
common/rvDecodePkg.sv
decode/immGen.sv
decode/writebackSelect.sv
decode/registerFile.sv
decode/decodeStage.sv
tb/decodeStage_asserts.sv
tb/decodeStageTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= decodeStageTb
FILELIST  ?= decodeStage.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= Simulation finished: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
